/* jtag_tap_ctrl.f */
hdl/tap_state_pkg.sv
hdl/tap_exec_pkg.sv
hdl/tap_state_tracker.sv
hdl/trst_sequencer.sv
hdl/scan_sequencer.sv
hdl/tap_pin_driver.sv
hdl/tap_controller.sv
sim/tb_tap_controller.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module tb_tap_controller \
	-f jtag_tap_ctrl.f \
	--Mdir obj_dir

./obj_dir/Vtb_tap_controller > sim.log
cat sim.log

if grep -q "Done: errors found" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

/* sim/tb_tap_controller.sv */
`default_nettype none

module tb_tap_controller
	import tap_state_pkg::*;
	import tap_exec_pkg::*;
();

	localparam int LEN_W         = 16;
	localparam int TRST_PULSES   = 5;
	localparam int READY_TIMEOUT = 2000; // cycles per tap_ready pulse
	localparam int QUIET_CYCLES  = 100;

	logic             clk;
	logic             reset;
	logic [7:0]       exec_state;
	logic [7:0]       low_level_cmd;
	logic [7:0]       sxr_type;
	logic [LEN_W-1:0] sxr_length;
	logic [7:0]       drv_byte;
	logic [7:0]       mask_byte;
	logic [7:0]       exp_byte;
	logic             tap_ready;
	logic             tck;
	logic             tms;
	logic             tdo;
	logic             trst;
	logic             mask_bit;
	logic             exp_bit;
	tap_state_t       tap_state;
	logic [LEN_W-1:0] bits_done;

	tap_state_t  model_state;
	logic        tck_prev;
	logic        tck_rose;
	int          scan_bits; // bits shifted since the last capture
	int          rise_count;
	int          trst_low_rises;
	int          sel_ir_rises;
	int          shift_ir_rises;
	int          shift_dr_rises;
	int          value_errors;
	int          other_errors;
	logic [15:0] lfsr;
	int          value;

	tap_controller #(
		.SXR_LEN_W      (LEN_W),
		.TRST_TCK_PULSES(TRST_PULSES)
	) dut_i (
		.clk          (clk),
		.reset        (reset),
		.exec_state   (exec_state),
		.low_level_cmd(low_level_cmd),
		.sxr_type     (sxr_type),
		.sxr_length   (sxr_length),
		.drv_byte     (drv_byte),
		.mask_byte    (mask_byte),
		.exp_byte     (exp_byte),
		.tap_ready    (tap_ready),
		.tck          (tck),
		.tms          (tms),
		.tdo          (tdo),
		.trst         (trst),
		.mask_bit     (mask_bit),
		.exp_bit      (exp_bit),
		.tap_state    (tap_state),
		.bits_done    (bits_done)
	);

	always #20 clk = ~clk;

	// reference TAP diagram grouped by tms value
	function automatic tap_state_t model_next(input tap_state_t s, input logic m);
		tap_state_t n;
		if (m) begin
			case (s)
				test_logic_reset, select_ir_scan:     n = test_logic_reset;
				run_test_idle, update_dr, update_ir: n = select_dr_scan;
				select_dr_scan:                      n = select_ir_scan;
				capture_dr, shift_dr:                n = exit1_dr;
				exit1_dr, exit2_dr:                  n = update_dr;
				pause_dr:                            n = exit2_dr;
				capture_ir, shift_ir:                n = exit1_ir;
				exit1_ir, exit2_ir:                  n = update_ir;
				default:                             n = exit2_ir; // pause_ir
			endcase
		end else begin
			case (s)
				test_logic_reset, run_test_idle, update_dr, update_ir: n = run_test_idle;
				select_dr_scan:                  n = capture_dr;
				capture_dr, shift_dr, exit2_dr:  n = shift_dr;
				exit1_dr, pause_dr:              n = pause_dr;
				select_ir_scan:                  n = capture_ir;
				capture_ir, shift_ir, exit2_ir:  n = shift_ir;
				default:                         n = pause_ir; // exit1_ir, pause_ir
			endcase
		end
		return n;
	endfunction

	// lsb first inside each 8-bit segment
	function automatic logic expected_bit(input logic [7:0] seg, input int count);
		return seg[count % 8];
	endfunction

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hb400;
		end
		return s >> 1;
	endfunction

	task automatic random_bits(input int nbits, output int result);
		result = 0;
		for (int i = 0; i < nbits; i++) begin
			lfsr   = lfsr_next(lfsr);
			result = (result << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			value_errors++;
			$display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
		end
	endtask

	// compares the pins against the model at every tck rise
	always @(negedge clk) begin
		tck_rose = tck && !tck_prev;
		if (!reset) begin
			tck_prev       <= 1'b0;
			model_state    <= test_logic_reset;
			scan_bits      <= 0;
			rise_count     <= 0;
			trst_low_rises <= 0;
			sel_ir_rises   <= 0;
			shift_ir_rises <= 0;
			shift_dr_rises <= 0;
		end else begin
			tck_prev <= tck;
			if (tck_rose) begin
				rise_count <= rise_count + 1;
				check_value("tap_state", tap_state, model_state);
				if (!trst) trst_low_rises <= trst_low_rises + 1;
				if (model_state == select_ir_scan) sel_ir_rises <= sel_ir_rises + 1;
				if (model_state == shift_ir) shift_ir_rises <= shift_ir_rises + 1;
				if (model_state == shift_dr) shift_dr_rises <= shift_dr_rises + 1;
				if (model_state == capture_dr || model_state == capture_ir) begin
					scan_bits <= 0;
				end
				if (model_state == shift_dr || model_state == shift_ir) begin
					check_value("tdo", tdo, expected_bit(drv_byte, scan_bits));
					check_value("mask_bit", mask_bit, expected_bit(mask_byte, scan_bits));
					check_value("exp_bit", exp_bit, expected_bit(exp_byte, scan_bits));
					check_value("bits_done", bits_done, scan_bits);
					scan_bits <= scan_bits + 1;
				end
			end
			if (!trst) begin
				model_state <= test_logic_reset;
			end else if (tck_rose) begin
				model_state <= model_next(model_state, tms);
			end
		end
	end

	// returns on the cycle after the low pulse
	task automatic wait_ready_pulse(input string what, output bit ok);
		int cycles;
		ok     = 1'b0;
		cycles = 0;
		while (!ok && cycles < READY_TIMEOUT) begin
			@(negedge clk);
			cycles++;
			if (!tap_ready) ok = 1'b1;
		end
		if (!ok) begin
			other_errors++;
			$display("timeout: no tap_ready pulse during %s within %0d cycles", what, cycles);
		end else begin
			@(negedge clk);
			check_value("tap_ready", tap_ready, 1'b1); // one cycle only
		end
	endtask

	task automatic check_reset_values();
		check_value("tck", tck, 1'b0);
		check_value("tms", tms, 1'b1);
		check_value("trst", trst, 1'b1);
		check_value("tap_ready", tap_ready, 1'b1);
		check_value("tdo", tdo, 1'b0);
		check_value("tap_state", tap_state, test_logic_reset);
		check_value("bits_done", bits_done, 0);
	endtask

	task automatic hard_trst();
		int  rises_before;
		bit  ok;
		@(negedge clk);
		low_level_cmd <= llc_hs_trst;
		exec_state    <= exec_llc_ready;
		rises_before = trst_low_rises;
		wait_ready_pulse("hard trst", ok);
		if (ok) begin
			check_value("tck rises with trst low", trst_low_rises - rises_before, TRST_PULSES);
			check_value("trst", trst, 1'b1);
			check_value("tap_state", tap_state, test_logic_reset);
		end
		exec_state <= exec_idle;
	endtask

	task automatic unknown_command();
		int rises_before;
		int low_cycles;
		@(negedge clk);
		low_level_cmd <= 8'h5a;
		exec_state    <= exec_llc_ready;
		rises_before = rise_count;
		low_cycles   = 0;
		for (int i = 0; i < QUIET_CYCLES; i++) begin
			@(negedge clk);
			if (!tap_ready) low_cycles++;
		end
		check_value("tck rises after unknown command", rise_count - rises_before, 0);
		check_value("tap_ready low cycles", low_cycles, 0);
		exec_state <= exec_idle;
	endtask

	task automatic load_bytes();
		int r;
		random_bits(8, r);
		drv_byte <= r[7:0];
		random_bits(8, r);
		mask_byte <= r[7:0];
		random_bits(8, r);
		exp_byte <= r[7:0];
	endtask

	task automatic run_scan(input logic [7:0] kind, input int len);
		string what;
		int    segs_expected;
		int    segs_seen;
		int    pause;
		int    rises_before;
		int    sel_ir_before;
		int    shift_ir_before;
		int    shift_dr_before;
		bit    ok;
		bit    finished;
		what          = (kind == sxr_sir) ? "sir scan" : "sdr scan";
		segs_expected = (len + 7) / 8 - 1;
		segs_seen     = 0;
		ok            = 1'b1;
		finished      = 1'b0;
		@(negedge clk);
		sxr_type   <= kind;
		sxr_length <= LEN_W'(len);
		load_bytes();
		exec_state <= exec_segment_ready;
		sel_ir_before   = sel_ir_rises;
		shift_ir_before = shift_ir_rises;
		shift_dr_before = shift_dr_rises;
		while (ok && !finished && segs_seen <= segs_expected) begin
			wait_ready_pulse(what, ok);
			if (ok) begin
				if (model_state == run_test_idle) begin
					finished = 1'b1;
				end else begin
					segs_seen++;
					exec_state <= exec_idle;
					random_bits(4, pause);
					rises_before = rise_count;
					repeat (pause + 1) @(negedge clk); // host takes its time
					check_value("tck rises during segment wait", rise_count - rises_before, 0);
					load_bytes();
					exec_state <= exec_segment_ready;
				end
			end
		end
		exec_state <= exec_idle;
		if (ok && !finished) begin
			other_errors++;
			$display("%s of %0d bits did not end after %0d segment pulses", what, len, segs_seen);
		end
		if (finished) begin
			check_value("tap_state at end", tap_state, run_test_idle);
			check_value("bits_done", bits_done, len);
			check_value("model bit count", scan_bits, len);
			check_value("segment pulses", segs_seen, segs_expected);
			if (kind == sxr_sir) begin
				check_value("select_ir_scan visited", sel_ir_rises > sel_ir_before, 1'b1);
				check_value("shift_ir bits", shift_ir_rises - shift_ir_before, len);
				check_value("shift_dr bits", shift_dr_rises - shift_dr_before, 0);
			end else begin
				check_value("select_ir_scan visits", sel_ir_rises - sel_ir_before, 0);
				check_value("shift_dr bits", shift_dr_rises - shift_dr_before, len);
				check_value("shift_ir bits", shift_ir_rises - shift_ir_before, 0);
			end
		end
	endtask

	initial begin
		clk           = 1'b0;
		reset         = 1'b0;
		exec_state    = exec_idle;
		low_level_cmd = 8'h00;
		sxr_type      = 8'h00;
		sxr_length    = '0;
		drv_byte      = 8'h00;
		mask_byte     = 8'h00;
		exp_byte      = 8'h00;
		lfsr          = 16'd22468;
		value_errors  = 0;
		other_errors  = 0;

		repeat (3) @(negedge clk);
		reset <= 1'b1;
		@(negedge clk);
		check_reset_values();

		hard_trst();
		unknown_command();

		random_bits(3, value);
		run_scan(sxr_sdr, value + 1); // short scans of 1 to 8 bits
		random_bits(3, value);
		run_scan(sxr_sir, value + 1);

		hard_trst(); // leaves run-test/idle this time

		random_bits(5, value);
		run_scan(sxr_sdr, value + 9); // 9 to 40 bits
		random_bits(5, value);
		run_scan(sxr_sir, value + 9);
		random_bits(5, value);
		run_scan(sxr_sdr, value + 9);

		$display("error count: %0d value mismatches, %0d other failures",
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/tap_controller.sv */
`default_nettype none

module tap_controller
	import tap_state_pkg::*;
	import tap_exec_pkg::*;
#(
	parameter int SXR_LEN_W       = 16,
	parameter int TRST_TCK_PULSES = 5
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [7:0]           exec_state,
	input  logic [7:0]           low_level_cmd,
	input  logic [7:0]           sxr_type,
	input  logic [SXR_LEN_W-1:0] sxr_length,
	input  logic [SEGMENT_W-1:0] drv_byte,
	input  logic [SEGMENT_W-1:0] mask_byte,
	input  logic [SEGMENT_W-1:0] exp_byte,
	output logic                 tap_ready,
	output logic                 tck,
	output logic                 tms,
	output logic                 tdo,
	output logic                 trst,
	output logic                 mask_bit,
	output logic                 exp_bit,
	output tap_state_t           tap_state,
	output logic [SXR_LEN_W-1:0] bits_done
);

	logic llc_tck;
	logic llc_trst;
	logic llc_done;
	logic scan_busy;
	logic scan_tck;
	logic scan_tms;
	logic scan_tdo;
	logic seg_request;
	logic tck_rise;

	trst_sequencer #(
		.TRST_TCK_PULSES(TRST_TCK_PULSES)
	) trst_seq_i (
		.clk          (clk),
		.reset        (reset),
		.exec_state   (exec_state),
		.low_level_cmd(low_level_cmd),
		.busy         (),
		.tck          (llc_tck),
		.trst         (llc_trst),
		.done         (llc_done)
	);

	scan_sequencer #(
		.SXR_LEN_W(SXR_LEN_W)
	) scan_seq_i (
		.clk        (clk),
		.reset      (reset),
		.exec_state (exec_state),
		.sxr_type   (sxr_type),
		.sxr_length (sxr_length),
		.drv_byte   (drv_byte),
		.mask_byte  (mask_byte),
		.exp_byte   (exp_byte),
		.tap_state  (tap_state),
		.tck_rise   (tck_rise),
		.busy       (scan_busy),
		.tck        (scan_tck),
		.tms        (scan_tms),
		.tdo_bit    (scan_tdo),
		.mask_bit   (mask_bit),
		.exp_bit    (exp_bit),
		.seg_request(seg_request),
		.bits_done  (bits_done)
	);

	tap_pin_driver pin_drv_i (
		.clk        (clk),
		.reset      (reset),
		.scan_busy  (scan_busy),
		.scan_tck   (scan_tck),
		.scan_tms   (scan_tms),
		.scan_tdo   (scan_tdo),
		.llc_tck    (llc_tck),
		.llc_trst   (llc_trst),
		.llc_done   (llc_done),
		.seg_request(seg_request),
		.tck        (tck),
		.tms        (tms),
		.tdo        (tdo),
		.trst       (trst),
		.tap_ready  (tap_ready)
	);

	// follows the pins as the target sees them
	tap_state_tracker tracker_i (
		.clk     (clk),
		.reset   (reset),
		.tck     (tck),
		.tms     (tms),
		.trst    (trst),
		.state   (tap_state),
		.tck_rise(tck_rise)
	);

endmodule

`default_nettype wire

/* hdl/tap_pin_driver.sv */
`default_nettype none

module tap_pin_driver (
	input  logic clk,
	input  logic reset,
	input  logic scan_busy,
	input  logic scan_tck,
	input  logic scan_tms,
	input  logic scan_tdo,
	input  logic llc_tck,
	input  logic llc_trst,
	input  logic llc_done,
	input  logic seg_request,
	output logic tck,
	output logic tms,
	output logic tdo,
	output logic trst,
	output logic tap_ready
);

	always_ff @(posedge clk) begin
		if (!reset) begin
			tck       <= 1'b0;
			tms       <= 1'b1;
			tdo       <= 1'b0;
			trst      <= 1'b1;
			tap_ready <= 1'b1;
		end else begin
			if (scan_busy) begin
				tck  <= scan_tck;
				tms  <= scan_tms;
				tdo  <= scan_tdo;
				trst <= 1'b1;
			end else begin
				tck  <= llc_tck;
				tms  <= 1'b1; // keeps the tap in test-logic-reset during trst pulses
				tdo  <= 1'b0;
				trst <= llc_trst;
			end
			tap_ready <= !(llc_done || seg_request); // one cycle low per event
		end
	end

endmodule

`default_nettype wire

/* hdl/scan_sequencer.sv */
`default_nettype none

module scan_sequencer
	import tap_state_pkg::*;
	import tap_exec_pkg::*;
#(
	parameter int SXR_LEN_W = 16
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [7:0]           exec_state,
	input  logic [7:0]           sxr_type,
	input  logic [SXR_LEN_W-1:0] sxr_length,
	input  logic [SEGMENT_W-1:0] drv_byte,
	input  logic [SEGMENT_W-1:0] mask_byte,
	input  logic [SEGMENT_W-1:0] exp_byte,
	input  tap_state_t           tap_state,
	input  logic                 tck_rise,
	output logic                 busy,
	output logic                 tck,
	output logic                 tms,
	output logic                 tdo_bit,
	output logic                 mask_bit,
	output logic                 exp_bit,
	output logic                 seg_request,
	output logic [SXR_LEN_W-1:0] bits_done
);

	// one tck step is set, rise, hold, decide
	typedef enum logic [2:0] {
		sc_idle,
		sc_decide,
		sc_set,
		sc_rise,
		sc_hold,
		sc_wait
	} scan_phase_t;

	scan_phase_t          phase;
	logic                 seg_ready;
	logic                 seg_q;
	logic                 go;
	logic                 in_shift;    // state before the coming rise was shift
	logic                 past_update; // rti now means the scan is over
	logic                 is_sir;
	logic                 shifting;
	logic                 counted;
	logic [SXR_LEN_W-1:0] bits_next;
	logic [SXR_LEN_W-1:0] len_m1;
	logic                 last_bit;

	assign seg_ready = exec_state == exec_segment_ready;
	assign is_sir    = sxr_type == sxr_sir;
	assign shifting  = (tap_state == shift_dr) || (tap_state == shift_ir);
	assign counted   = tck_rise && in_shift;
	assign bits_next = bits_done + SXR_LEN_W'(counted);
	assign len_m1    = sxr_length - 1'b1;
	assign last_bit  = bits_next == len_m1;

	always_ff @(posedge clk) begin
		if (!reset) begin
			phase       <= sc_idle;
			seg_q       <= 1'b0;
			go          <= 1'b0;
			tms         <= 1'b1;
			in_shift    <= 1'b0;
			past_update <= 1'b0;
			seg_request <= 1'b0;
			bits_done   <= '0;
		end else begin
			seg_q       <= seg_ready;
			go          <= seg_ready && !seg_q;
			seg_request <= 1'b0;

			case (phase)
				sc_idle: begin
					if (go) begin
						if (sxr_type == sxr_sdr || is_sir) begin
							phase       <= sc_decide;
							bits_done   <= '0;
							in_shift    <= 1'b0;
							past_update <= 1'b0;
						end else begin
							seg_request <= 1'b1; // unknown scan type
						end
					end
				end
				sc_set:  phase <= sc_rise;
				sc_rise: phase <= sc_hold;
				sc_hold: phase <= sc_decide;
				sc_wait: begin
					if (go) begin
						tms   <= bits_done == len_m1;
						phase <= sc_set;
					end
				end
				sc_decide: begin
					bits_done <= bits_next;
					in_shift  <= shifting;
					phase     <= sc_set;
					case (tap_state)
						test_logic_reset: tms <= 1'b0;
						run_test_idle: begin
							if (past_update) begin
								phase       <= sc_idle; // scan complete
								seg_request <= 1'b1;
							end else begin
								tms <= 1'b1;
							end
						end
						select_dr_scan: tms <= is_sir;
						select_ir_scan, capture_ir: begin
							if (is_sir) begin
								tms <= 1'b0;
							end else begin
								phase       <= sc_idle;
								seg_request <= 1'b1;
							end
						end
						capture_dr: begin
							if (!is_sir) begin
								tms <= 1'b0;
							end else begin
								phase       <= sc_idle;
								seg_request <= 1'b1;
							end
						end
						shift_dr, shift_ir: begin
							if (counted && bits_next[SEG_IDX_W-1:0] == '0) begin
								phase       <= sc_wait; // segment used up, tck parked low
								seg_request <= 1'b1;
							end else begin
								tms <= last_bit;
							end
						end
						exit1_dr, exit1_ir: tms <= 1'b1;
						update_dr, update_ir: begin
							tms         <= 1'b0;
							past_update <= 1'b1;
						end
						default: begin
							phase       <= sc_idle; // pause states are not scan targets
							seg_request <= 1'b1;
						end
					endcase
				end
				default: phase <= sc_idle;
			endcase
		end
	end

	assign busy = phase != sc_idle;
	assign tck  = (phase == sc_rise) || (phase == sc_hold);

	// lsb first within each segment
	assign tdo_bit  = drv_byte[bits_done[SEG_IDX_W-1:0]];
	assign mask_bit = mask_byte[bits_done[SEG_IDX_W-1:0]];
	assign exp_bit  = exp_byte[bits_done[SEG_IDX_W-1:0]];

endmodule

`default_nettype wire

/* hdl/trst_sequencer.sv */
`default_nettype none

module trst_sequencer
	import tap_exec_pkg::*;
#(
	parameter int TRST_TCK_PULSES = 5
) (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] exec_state,
	input  logic [7:0] low_level_cmd,
	output logic       busy,
	output logic       tck,
	output logic       trst,
	output logic       done
);

	// phase 0 trst low, then 2 phases per pulse, one with trst high, one for done
	localparam int PULSE_END  = 2 * TRST_TCK_PULSES;
	localparam int LAST_PHASE = PULSE_END + 2;
	localparam int PHASE_W    = $clog2(LAST_PHASE + 1);

	logic               llc_ready;
	logic               llc_q;
	logic               go;
	logic [PHASE_W-1:0] phase;

	assign llc_ready = exec_state == exec_llc_ready;

	always_ff @(posedge clk) begin
		if (!reset) begin
			llc_q <= 1'b0;
			go    <= 1'b0;
			busy  <= 1'b0;
			phase <= '0;
		end else begin
			llc_q <= llc_ready;
			go    <= llc_ready && !llc_q; // one cycle per new command

			if (!busy) begin
				if (go && low_level_cmd == llc_hs_trst) begin
					busy  <= 1'b1;
					phase <= '0;
				end
			end else if (phase == PHASE_W'(LAST_PHASE)) begin
				busy <= 1'b0;
			end else begin
				phase <= phase + 1'b1;
			end
		end
	end

	// odd phases below PULSE_END are the high halves of the pulses
	assign tck  = busy && phase[0] && (phase < PHASE_W'(PULSE_END));
	assign trst = !busy || (phase > PHASE_W'(PULSE_END));
	assign done = busy && (phase == PHASE_W'(LAST_PHASE));

endmodule

`default_nettype wire

/* hdl/tap_state_tracker.sv */
`default_nettype none

module tap_state_tracker
	import tap_state_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       tck,
	input  logic       tms,
	input  logic       trst,
	output tap_state_t state,
	output logic       tck_rise
);

	logic tck_q; // tck level of the previous cycle

	always_ff @(posedge clk) begin
		if (!reset) begin
			tck_q    <= 1'b0;
			state    <= test_logic_reset;
			tck_rise <= 1'b0;
		end else begin
			tck_q    <= tck;
			tck_rise <= 1'b0;
			if (!trst) begin
				state <= test_logic_reset; // async trst of the target seen on clk
			end else if (tck && !tck_q) begin
				state    <= tap_next(state, tms);
				tck_rise <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/tap_exec_pkg.sv */
`default_nettype none

package tap_exec_pkg;

	// executor states seen from the host
	typedef enum logic [7:0] {
		exec_idle          = 8'h00,
		exec_llc_ready     = 8'h10, // low-level command fetched
		exec_segment_ready = 8'h20  // next vector segment loaded
	} exec_state_t;

	// low-level commands
	localparam logic [7:0] llc_hs_trst = 8'h01;

	// scan types
	localparam logic [7:0] sxr_sdr = 8'h80;
	localparam logic [7:0] sxr_sir = 8'h81;

	localparam int SEGMENT_W = 8;
	localparam int SEG_IDX_W = $clog2(SEGMENT_W); // bit index within a segment

endpackage

`default_nettype wire

/* hdl/tap_state_pkg.sv */
`default_nettype none

package tap_state_pkg;

	// IEEE 1149.1 controller states
	typedef enum logic [3:0] {
		test_logic_reset,
		run_test_idle,
		select_dr_scan,
		capture_dr,
		shift_dr,
		exit1_dr,
		pause_dr,
		exit2_dr,
		update_dr,
		select_ir_scan,
		capture_ir,
		shift_ir,
		exit1_ir,
		pause_ir,
		exit2_ir,
		update_ir
	} tap_state_t;

	// state taken on a rising tck
	function automatic tap_state_t tap_next(input tap_state_t cur, input logic tms);
		case (cur)
			test_logic_reset: return tms ? test_logic_reset : run_test_idle;
			run_test_idle:    return tms ? select_dr_scan : run_test_idle;
			select_dr_scan:   return tms ? select_ir_scan : capture_dr;
			capture_dr:       return tms ? exit1_dr : shift_dr;
			shift_dr:         return tms ? exit1_dr : shift_dr;
			exit1_dr:         return tms ? update_dr : pause_dr;
			pause_dr:         return tms ? exit2_dr : pause_dr;
			exit2_dr:         return tms ? update_dr : shift_dr;
			update_dr:        return tms ? select_dr_scan : run_test_idle;
			select_ir_scan:   return tms ? test_logic_reset : capture_ir;
			capture_ir:       return tms ? exit1_ir : shift_ir;
			shift_ir:         return tms ? exit1_ir : shift_ir;
			exit1_ir:         return tms ? update_ir : pause_ir;
			pause_ir:         return tms ? exit2_ir : pause_ir;
			exit2_ir:         return tms ? update_ir : shift_ir;
			update_ir:        return tms ? select_dr_scan : run_test_idle;
			default:          return test_logic_reset;
		endcase
	endfunction

endpackage

`default_nettype wire
